// File: vfrag_defs.svh
/*
 * Vector request fragmenter parameters
 * Address, page, length and id widths shared by package and RTL
 */
`ifndef VFRAG_DEFS_SVH
`define VFRAG_DEFS_SVH

// Byte address width
`define VFRAG_ADDR_W 32

// Page of 4096 bytes
`define VFRAG_PAGE_BITS 12

// Element count and vstart width
`define VFRAG_LEN_W 16

// Request id width
`define VFRAG_ID_W 4

// Segment byte count, up to len elements of 8 bytes
`define VFRAG_SEG_BYTES_W (`VFRAG_LEN_W + 3)

// Transaction index within a segment, page crossings plus one
`define VFRAG_TXN_IDX_W (`VFRAG_SEG_BYTES_W + 1 - `VFRAG_PAGE_BITS)

`endif

// File: vfrag_pkg.sv
/*
 * Vector request fragmenter types
 * Mode and state encodings, request, segment and transaction records
 */
`include "vfrag_defs.svh"

package vfrag_pkg;

  // -------------------------------------------------------------------------
  // Encodings
  // -------------------------------------------------------------------------

  // Addressing mode, codes 2 and 3 are reserved and run as incremental
  typedef enum logic [1:0] {
    MODE_INCR = 2'd0,
    MODE_STRD = 2'd1
  } vfrag_mode_e;

  // Control states
  typedef enum logic [1:0] {
    ST_IDLE     = 2'd0,
    ST_SEG_INIT = 2'd1,
    ST_STALL    = 2'd2,
    ST_FRAG     = 2'd3
  } vfrag_state_e;

  // -------------------------------------------------------------------------
  // Records
  // -------------------------------------------------------------------------

  // Incoming vector memory request
  typedef struct packed {
    logic [`VFRAG_ID_W-1:0]   req_id;
    vfrag_mode_e              mode;
    logic [`VFRAG_ADDR_W-1:0] base_addr;
    logic [`VFRAG_ADDR_W-1:0] stride;     // byte stride, strided mode only
    logic [`VFRAG_LEN_W-1:0]  len;
    logic [`VFRAG_LEN_W-1:0]  vstart;
    logic [1:0]               sew;        // element bytes = 1 << sew
  } vfrag_req_t;

  // One contiguous segment
  typedef struct packed {
    logic [`VFRAG_ADDR_W-1:0]      seg_addr;
    logic [`VFRAG_SEG_BYTES_W-1:0] seg_bytes;
    logic [`VFRAG_TXN_IDX_W-1:0]   txn_last_idx;
  } vfrag_seg_t;

  // Outgoing page-bounded transaction
  typedef struct packed {
    logic [`VFRAG_ID_W-1:0]     req_id;
    logic [`VFRAG_ADDR_W-1:0]   addr;
    logic [`VFRAG_PAGE_BITS:0]  nbytes;
    logic                       last;
  } vfrag_txn_t;

endpackage

// File: vfrag_seg_init.sv
/*
 * Segment initializer
 * Byte count and page-crossing count of a segment from its start address
 */
`include "vfrag_defs.svh"

module vfrag_seg_init (
  input  logic [`VFRAG_ADDR_W-1:0] seg_addr_i,
  input  vfrag_pkg::vfrag_mode_e   mode_i,
  input  logic [1:0]               sew_i,
  input  logic [`VFRAG_LEN_W-1:0]  nr_elems_i,
  output vfrag_pkg::vfrag_seg_t    seg_o
);
  import vfrag_pkg::*;

  // Page offset plus segment bytes needs one bit above the byte count
  localparam int unsigned SpanW = `VFRAG_SEG_BYTES_W + 1;

  logic [`VFRAG_LEN_W-1:0]       seg_elems;
  logic [`VFRAG_SEG_BYTES_W-1:0] seg_bytes;
  logic [`VFRAG_PAGE_BITS-1:0]   page_off;
  logic [SpanW-1:0]              span;
  logic [SpanW-1:0]              span_last;

  always_comb begin
    // Strided segments hold one element
    // Incremental and reserved codes take all remaining elements
    if (mode_i == MODE_STRD) begin
      seg_elems = `VFRAG_LEN_W'(1);
    end else begin
      seg_elems = nr_elems_i;
    end

    // Elements to bytes
    seg_bytes = `VFRAG_SEG_BYTES_W'(seg_elems) << sew_i;

    // Offset of the first byte inside its page
    page_off  = seg_addr_i[`VFRAG_PAGE_BITS-1:0];

    // Last byte position counted from the page base
    span      = SpanW'(page_off) + SpanW'(seg_bytes);
    span_last = span - SpanW'(1);

    // Page number of the last byte is the number of crossings
    seg_o.seg_addr     = seg_addr_i;
    seg_o.seg_bytes    = seg_bytes;
    seg_o.txn_last_idx = span_last[SpanW-1:`VFRAG_PAGE_BITS];
  end

endmodule

// File: vfrag_seg_counter.sv
/*
 * Segment and transaction counter
 * Tracks remaining segments and the transaction index in the segment
 */
`include "vfrag_defs.svh"

module vfrag_seg_counter (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    load_req_i,
  input  logic [`VFRAG_LEN_W-1:0] nr_segs_i,
  input  logic                    seg_start_i,
  input  vfrag_pkg::vfrag_seg_t   seg_i,
  input  logic                    advance_i,
  output logic                    last_txn_o,
  output logic                    last_seg_o
);
  import vfrag_pkg::*;

  logic [`VFRAG_LEN_W-1:0]     rmn_segs_r;
  logic [`VFRAG_TXN_IDX_W-1:0] txn_idx_r;
  logic [`VFRAG_TXN_IDX_W-1:0] last_idx_r;

  // Flags for the control FSM
  assign last_txn_o = (txn_idx_r == last_idx_r);
  assign last_seg_o = (rmn_segs_r == '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rmn_segs_r <= '0;
      txn_idx_r  <= '0;
      last_idx_r <= '0;
    end else begin
      // Segments left after the current one
      // A start together with an advance moves on from a finished segment
      if (load_req_i) begin
        rmn_segs_r <= nr_segs_i;
      end else if (seg_start_i && advance_i) begin
        rmn_segs_r <= rmn_segs_r - `VFRAG_LEN_W'(1);
      end

      // Index restarts with each segment
      // Holds on the final transaction of the request
      if (seg_start_i) begin
        txn_idx_r  <= '0;
        last_idx_r <= seg_i.txn_last_idx;
      end else if (advance_i && !last_txn_o) begin
        txn_idx_r  <= txn_idx_r + `VFRAG_TXN_IDX_W'(1);
      end
    end
  end

  // -------------------------------------------------------------------------
  // Assertions
  // -------------------------------------------------------------------------

  // FSM restarts the index before it runs past the segment
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (advance_i && last_txn_o) |-> (seg_start_i || last_seg_o));

  // No new segment is started once the last one is running
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (seg_start_i && advance_i) |-> (rmn_segs_r != '0));

endmodule

// File: vfrag_txn_gen.sv
/*
 * Transaction generator
 * Holds request and segment state and forms page-bounded transactions
 */
`include "vfrag_defs.svh"

module vfrag_txn_gen (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    load_req_i,
  input  vfrag_pkg::vfrag_req_t   req_i,
  input  logic                    seg_start_i,
  input  logic                    advance_i,
  input  logic                    last_txn_i,
  input  logic                    last_seg_i,
  output logic [`VFRAG_LEN_W-1:0] nr_segs_o,
  output vfrag_pkg::vfrag_seg_t   seg_o,
  output vfrag_pkg::vfrag_txn_t   txn_o
);
  import vfrag_pkg::*;

  localparam int unsigned PageSize = 1 << `VFRAG_PAGE_BITS;
  localparam int unsigned NbW      = `VFRAG_PAGE_BITS + 1;

  vfrag_req_t                    req_r;
  vfrag_seg_t                    seg_r;
  logic [`VFRAG_ADDR_W-1:0]      cur_addr_r;
  logic [`VFRAG_ADDR_W-1:0]      first_addr;
  logic [`VFRAG_ADDR_W-1:0]      next_seg_addr;
  logic [`VFRAG_ADDR_W-1:0]      seg_end;
  logic [`VFRAG_LEN_W-1:0]       nr_elems;
  logic [`VFRAG_SEG_BYTES_W-1:0] rmn_bytes;
  logic [NbW-1:0]                page_room;
  logic [NbW-1:0]                nbytes;

  // -------------------------------------------------------------------------
  // Request decode
  // -------------------------------------------------------------------------

  // Segments minus one, taken by the counter in the accepting cycle
  always_comb begin
    if (req_i.mode == MODE_STRD) begin
      nr_segs_o = req_i.len - req_i.vstart - `VFRAG_LEN_W'(1);
    end else begin
      nr_segs_o = '0;
    end
  end

  // Elements left after vstart
  assign nr_elems = req_r.len - req_r.vstart;

  // First element address, vstart scaled by element size or by stride
  always_comb begin
    if (req_r.mode == MODE_STRD) begin
      first_addr = req_r.base_addr + `VFRAG_ADDR_W'(req_r.vstart) * req_r.stride;
    end else begin
      first_addr = req_r.base_addr + (`VFRAG_ADDR_W'(req_r.vstart) << req_r.sew);
    end
  end

  // Start in ST_SEG_INIT has no advance and picks the first address
  // Later starts step one stride on from the previous segment
  assign next_seg_addr = advance_i ? (seg_r.seg_addr + req_r.stride) : first_addr;

  // Single shared initializer for every segment start
  vfrag_seg_init i_seg_init (
    .seg_addr_i (next_seg_addr),
    .mode_i     (req_r.mode),
    .sew_i      (req_r.sew),
    .nr_elems_i (nr_elems),
    .seg_o      (seg_o)
  );

  // -------------------------------------------------------------------------
  // Transaction sizing
  // -------------------------------------------------------------------------

  // Bytes left up to the segment end
  assign seg_end   = seg_r.seg_addr + `VFRAG_ADDR_W'(seg_r.seg_bytes);
  assign rmn_bytes = `VFRAG_SEG_BYTES_W'(seg_end - cur_addr_r);

  // Bytes left up to the next page boundary
  assign page_room = NbW'(PageSize) - NbW'(cur_addr_r[`VFRAG_PAGE_BITS-1:0]);

  // Stop at whichever comes first
  assign nbytes = (rmn_bytes < `VFRAG_SEG_BYTES_W'(page_room)) ? NbW'(rmn_bytes)
                                                               : page_room;

  always_comb begin
    txn_o.req_id = req_r.req_id;
    txn_o.addr   = cur_addr_r;
    txn_o.nbytes = nbytes;
    txn_o.last   = last_txn_i && last_seg_i;
  end

  // -------------------------------------------------------------------------
  // State
  // -------------------------------------------------------------------------

  // Request fields, captured on acceptance
  always_ff @(posedge clk_i) begin
    if (load_req_i) begin
      req_r <= req_i;
    end
  end

  // Segment and walking address
  // Both stay put under back-pressure so txn_o holds
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seg_r      <= '0;
      cur_addr_r <= '0;
    end else if (seg_start_i) begin
      seg_r      <= seg_o;
      cur_addr_r <= seg_o.seg_addr;
    end else if (advance_i) begin
      cur_addr_r <= cur_addr_r + `VFRAG_ADDR_W'(nbytes);
    end
  end

endmodule

// File: vfrag_ctrl_fsm.sv
/*
 * Fragmenter control FSM
 * Sequences idle, segment init, stall and fragmenting with the enqueue pulse
 */
module vfrag_ctrl_fsm (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic req_valid_i,
  input  logic core_st_pending_i,
  input  logic meta_buf_full_i,
  input  logic txn_ready_i,
  input  logic last_txn_i,
  input  logic last_seg_i,
  output logic req_ready_o,
  output logic load_req_o,
  output logic seg_start_o,
  output logic advance_o,
  output logic txn_valid_o,
  output logic meta_buf_enq_o
);
  import vfrag_pkg::*;

  vfrag_state_e state_r;
  vfrag_state_e state_nxt;
  logic         start_frag_r;
  logic         start_frag_nxt;
  logic         stall;
  logic         final_txn;

  // Either resource busy holds off fragmenting
  assign stall = core_st_pending_i || meta_buf_full_i;

  // Handshakes
  assign req_ready_o = (state_r == ST_IDLE);
  assign load_req_o  = req_ready_o && req_valid_i;
  assign txn_valid_o = (state_r == ST_FRAG);
  assign advance_o   = txn_valid_o && txn_ready_i;

  // Last transaction of the last segment
  assign final_txn = last_txn_i && last_seg_i;

  // First segment in ST_SEG_INIT
  // Next segment when a non-final segment completes
  assign seg_start_o = (state_r == ST_SEG_INIT) || (advance_o && last_txn_i && !last_seg_i);

  // Enqueue pulse on the first ST_FRAG cycle only
  assign meta_buf_enq_o = start_frag_r;

  // -------------------------------------------------------------------------
  // Next state
  // -------------------------------------------------------------------------

  always_comb begin
    state_nxt = state_r;
    case (state_r)
      ST_IDLE: begin
        if (load_req_o) begin
          state_nxt = ST_SEG_INIT;
        end
      end
      // Segment loads here, then wait for resources if needed
      ST_SEG_INIT, ST_STALL: begin
        state_nxt = stall ? ST_STALL : ST_FRAG;
      end
      // Stall levels no longer matter once started
      ST_FRAG: begin
        if (advance_o && final_txn) begin
          state_nxt = ST_IDLE;
        end
      end
      default: begin
        state_nxt = ST_IDLE;
      end
    endcase
  end

  // Set on the edge into ST_FRAG, cleared one cycle later
  always_comb begin
    start_frag_nxt = 1'b0;
    if ((state_r == ST_SEG_INIT) || (state_r == ST_STALL)) begin
      start_frag_nxt = !stall;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_r      <= ST_IDLE;
      start_frag_r <= 1'b0;
    end else begin
      state_r      <= state_nxt;
      start_frag_r <= start_frag_nxt;
    end
  end

  // -------------------------------------------------------------------------
  // Assertions
  // -------------------------------------------------------------------------

  // Counter flags hold while a transaction waits for ready
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (txn_valid_o && !txn_ready_i) |=> $stable({last_txn_i, last_seg_i}));

  // Last segment stays last until the request ends
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (txn_valid_o && last_seg_i) |=> (!txn_valid_o || last_seg_i));

endmodule

// File: vfrag_top.sv
/*
 * Vector load/store request fragmenter
 * Cuts one vector request into page-bounded transactions
 */
`include "vfrag_defs.svh"

module vfrag_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Request port
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  input  vfrag_pkg::vfrag_req_t req_i,
  // Stall levels
  input  logic                  core_st_pending_i,
  input  logic                  meta_buf_full_i,
  // Transaction port
  output logic                  txn_valid_o,
  input  logic                  txn_ready_i,
  output vfrag_pkg::vfrag_txn_t txn_o,
  // Enqueue pulse
  output logic                  meta_buf_enq_o
);
  import vfrag_pkg::*;

  logic                    load_req;
  logic                    seg_start;
  logic                    advance;
  logic                    last_txn;
  logic                    last_seg;
  logic [`VFRAG_LEN_W-1:0] nr_segs;
  vfrag_seg_t              seg_init;

  // Sequencing
  vfrag_ctrl_fsm i_ctrl_fsm (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .req_valid_i       (req_valid_i),
    .core_st_pending_i (core_st_pending_i),
    .meta_buf_full_i   (meta_buf_full_i),
    .txn_ready_i       (txn_ready_i),
    .last_txn_i        (last_txn),
    .last_seg_i        (last_seg),
    .req_ready_o       (req_ready_o),
    .load_req_o        (load_req),
    .seg_start_o       (seg_start),
    .advance_o         (advance),
    .txn_valid_o       (txn_valid_o),
    .meta_buf_enq_o    (meta_buf_enq_o)
  );

  // Segment and transaction position
  vfrag_seg_counter i_seg_counter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .load_req_i  (load_req),
    .nr_segs_i   (nr_segs),
    .seg_start_i (seg_start),
    .seg_i       (seg_init),
    .advance_i   (advance),
    .last_txn_o  (last_txn),
    .last_seg_o  (last_seg)
  );

  // Request state, segment init and transaction forming
  vfrag_txn_gen i_txn_gen (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .load_req_i  (load_req),
    .req_i       (req_i),
    .seg_start_i (seg_start),
    .advance_i   (advance),
    .last_txn_i  (last_txn),
    .last_seg_i  (last_seg),
    .nr_segs_o   (nr_segs),
    .seg_o       (seg_init),
    .txn_o       (txn_o)
  );

endmodule

// File: tb_vfrag.sv
/*
 * Testbench for the vector request fragmenter
 * Replays the request trace, adds stalls and random back-pressure, checks transactions
 */
`include "vfrag_defs.svh"

module tb_vfrag;
  timeunit 1ns;
  timeprecision 1ps;

  import vfrag_pkg::*;

  localparam int MaxReqs     = 16;
  localparam int MaxTxns     = 64;
  localparam int AcceptLimit = 20;
  localparam int FragLimit   = 400;
  localparam int NbW         = `VFRAG_PAGE_BITS + 1;

  logic       clk_i;
  logic       rst_ni;
  logic       req_valid_i;
  logic       req_ready_o;
  vfrag_req_t req_i;
  logic       core_st_pending_i;
  logic       meta_buf_full_i;
  logic       txn_valid_o;
  logic       txn_ready_i;
  vfrag_txn_t txn_o;
  logic       meta_buf_enq_o;

  // Trace contents
  vfrag_req_t  req_tab      [MaxReqs];
  int          stall_kind   [MaxReqs];
  int          stall_cycles [MaxReqs];
  int          txn_first    [MaxReqs];
  int          txn_count    [MaxReqs];
  vfrag_txn_t  exp_txn      [MaxTxns];
  int          nr_reqs;
  int          nr_exp;
  logic [31:0] lcg_state;

  vfrag_top dut_i (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .req_valid_i       (req_valid_i),
    .req_ready_o       (req_ready_o),
    .req_i             (req_i),
    .core_st_pending_i (core_st_pending_i),
    .meta_buf_full_i   (meta_buf_full_i),
    .txn_valid_o       (txn_valid_o),
    .txn_ready_i       (txn_ready_i),
    .txn_o             (txn_o),
    .meta_buf_enq_o    (meta_buf_enq_o)
  );

  // 8 ns clock
  always #4 clk_i = ~clk_i;

  // -------------------------------------------------------------------------
  // Helpers
  // -------------------------------------------------------------------------

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [63:0] exp,
                             input logic [63:0] got);
    assert (got === exp)
    else abort_run($sformatf("ERROR at %0d ns: %s expected 0x%0h, got 0x%0h",
                             $time, name, exp, got));
  endtask

  // Ready is high about three cycles out of four
  function automatic logic next_ready();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return (lcg_state[17:16] != 2'b00);
  endfunction

  // R lines open a request, T lines that follow are its transactions
  task automatic load_trace();
    int          fd;
    int          rc;
    int          id;
    int          mode;
    int          len;
    int          vstart;
    int          sew;
    int          skind;
    int          scnt;
    int          nb;
    int          last;
    logic [31:0] base;
    logic [31:0] stride;
    logic [31:0] addr;
    string       line;
    byte         c;
    fd = $fopen("vfrag_trace.txt", "r");
    if (fd == 0) begin
      abort_run("Cannot open the trace file vfrag_trace.txt");
    end
    nr_reqs = 0;
    nr_exp  = 0;
    while (!$feof(fd)) begin
      line = "";
      rc   = $fgets(line, fd);
      c    = line.getc(0);
      if (c == "R") begin
        rc = $sscanf(line, "R %d %d %h %h %d %d %d %d %d",
                     id, mode, base, stride, len, vstart, sew, skind, scnt);
        if (rc != 9 || nr_reqs >= MaxReqs) begin
          abort_run("Trace has a malformed or excess request line");
        end
        req_tab[nr_reqs].req_id    = `VFRAG_ID_W'(id);
        req_tab[nr_reqs].mode      = vfrag_mode_e'(mode[1:0]);
        req_tab[nr_reqs].base_addr = base;
        req_tab[nr_reqs].stride    = stride;
        req_tab[nr_reqs].len       = `VFRAG_LEN_W'(len);
        req_tab[nr_reqs].vstart    = `VFRAG_LEN_W'(vstart);
        req_tab[nr_reqs].sew       = sew[1:0];
        stall_kind[nr_reqs]        = skind;
        stall_cycles[nr_reqs]      = scnt;
        txn_first[nr_reqs]         = nr_exp;
        txn_count[nr_reqs]         = 0;
        nr_reqs++;
      end else if (c == "T") begin
        rc = $sscanf(line, "T %h %d %d", addr, nb, last);
        if (rc != 3 || nr_reqs == 0 || nr_exp >= MaxTxns) begin
          abort_run("Trace has a malformed or misplaced transaction line");
        end
        exp_txn[nr_exp].req_id = req_tab[nr_reqs-1].req_id;
        exp_txn[nr_exp].addr   = addr;
        exp_txn[nr_exp].nbytes = NbW'(nb);
        exp_txn[nr_exp].last   = last[0];
        txn_count[nr_reqs-1]++;
        nr_exp++;
      end
    end
    $fclose(fd);
    if (nr_reqs == 0) begin
      abort_run("Trace holds no requests");
    end
  endtask

  // -------------------------------------------------------------------------
  // One request from offer to return of ready
  // -------------------------------------------------------------------------

  task automatic run_request(input int r);
    int         cyc;
    int         idx;
    int         scnt;
    logic       hold;
    vfrag_txn_t held;
    vfrag_txn_t exp;
    scnt = stall_cycles[r];
    hold = 1'b0;
    held = '0;
    idx  = 0;
    cyc  = 0;

    req_i       <= req_tab[r];
    req_valid_i <= 1'b1;
    do begin
      @(posedge clk_i);
      cyc++;
      if (cyc > AcceptLimit) begin
        abort_run("Timeout: request was never accepted");
      end
    end while (!req_ready_o);

    // Accepted on this edge, stall levels rise with it
    req_valid_i       <= 1'b0;
    core_st_pending_i <= (stall_kind[r] == 1) && (scnt > 0);
    meta_buf_full_i   <= (stall_kind[r] == 2) && (scnt > 0);
    txn_ready_i       <= next_ready();

    // First valid cycle is stall count plus two after acceptance
    cyc = 0;
    while (idx < txn_count[r]) begin
      @(posedge clk_i);
      cyc++;
      if (cyc > FragLimit) begin
        abort_run("Timeout: transactions of a request did not complete");
      end
      check_value("txn_valid_o", 64'(cyc >= scnt + 2), 64'(txn_valid_o));
      check_value("meta_buf_enq_o", 64'(cyc == scnt + 2), 64'(meta_buf_enq_o));
      if (hold) begin
        check_value("txn_o", 64'(held), 64'(txn_o));
      end
      if (txn_valid_o && txn_ready_i) begin
        exp = exp_txn[txn_first[r] + idx];
        check_value("txn_o.req_id", 64'(exp.req_id), 64'(txn_o.req_id));
        check_value("txn_o.addr", 64'(exp.addr), 64'(txn_o.addr));
        check_value("txn_o.nbytes", 64'(exp.nbytes), 64'(txn_o.nbytes));
        check_value("txn_o.last", 64'(exp.last), 64'(txn_o.last));
        idx++;
        hold = 1'b0;
      end else if (txn_valid_o) begin
        hold = 1'b1;
        held = txn_o;
      end
      if (cyc == scnt) begin
        core_st_pending_i <= 1'b0;
        meta_buf_full_i   <= 1'b0;
      end
      txn_ready_i <= next_ready();
    end

    // Back in idle one cycle after the last transaction
    @(posedge clk_i);
    check_value("req_ready_o", 64'(1), 64'(req_ready_o));
    check_value("txn_valid_o", 64'(0), 64'(txn_valid_o));
    check_value("meta_buf_enq_o", 64'(0), 64'(meta_buf_enq_o));
  endtask

  initial begin
    clk_i             = 1'b0;
    rst_ni            = 1'b0;
    req_valid_i       = 1'b0;
    req_i             = '0;
    core_st_pending_i = 1'b0;
    meta_buf_full_i   = 1'b0;
    txn_ready_i       = 1'b0;
    lcg_state         = 32'd93678;
    load_trace();

    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    check_value("req_ready_o", 64'(1), 64'(req_ready_o));
    check_value("txn_valid_o", 64'(0), 64'(txn_valid_o));
    check_value("meta_buf_enq_o", 64'(0), 64'(meta_buf_enq_o));

    for (int r = 0; r < nr_reqs; r++) begin
      run_request(r);
    end

    $display("Done: no errors");
    $finish;
  end

endmodule

// File: vfrag_trace.txt
# R id mode base_addr(hex) stride(hex) len vstart sew stall_kind stall_cycles
# T addr(hex) nbytes last, stall_kind 0 none, 1 core store pending, 2 meta buffer full
R 1 0 10000100 00000000 16 4 2 0 0
T 10000110 48 1
R 2 0 00002f00 00000000 128 0 3 1 3
T 00002f00 256 0
T 00003000 768 1
R 3 0 00005ff0 00000000 1053 2 2 2 2
T 00005ff8 8 0
T 00006000 4096 0
T 00007000 100 1
R 4 1 00010000 00000100 5 1 2 0 0
T 00010100 4 0
T 00010200 4 0
T 00010300 4 0
T 00010400 4 1
R 5 1 00020ff4 00000008 3 0 3 1 1
T 00020ff4 8 0
T 00020ffc 4 0
T 00021000 4 0
T 00021004 8 1
R 6 2 00030000 00000040 8 0 0 2 4
T 00030000 8 1

// File: tb.f
+incdir+.
vfrag_pkg.sv
vfrag_seg_init.sv
vfrag_seg_counter.sv
vfrag_txn_gen.sv
vfrag_ctrl_fsm.sv
vfrag_top.sv
tb_vfrag.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f tb.f --top-module tb_vfrag -o sim_vfrag
	./obj_dir/sim_vfrag | tee sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log
